/* Bender.yml */
package:
  name: link

sources:
  - source/link_pkg.sv
  - source/uart_tx.sv
  - source/uart_rx.sv
  - source/link_tx.sv
  - source/link_rx.sv
  - source/link_top.sv
  - target: test
    files:
      - bench/link_tb.sv

/* all.f */
source/link_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/link_tx.sv
source/link_rx.sv
source/link_top.sv
bench/link_tb.sv

/* bench/link_tb.sv */
`timescale 1ns/1ps

module link_tb import link_pkg::*; ();

    localparam int CLK_FREQ     = 50_000_000;
    localparam int BAUD_RATE    = 5_000_000;
    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam int TIMEOUT      = 2000;                  // Cycles per wait

    logic     clk;
    logic     rst_n;
    logic     send;
    nibble_t  send_data;
    logic     ready;
    logic     tx_line;
    logic     rx_line;
    logic     line_flip;                                 // Error mask on the loopback
    logic     rx_valid;
    rx_word_t rx_word;

    int checks;
    int errors;
    int valid_seen;                                      // rx_valid pulses so far

    assign rx_line = tx_line ^ line_flip;                // Loopback with injection

    link_top link_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .send      (send),
        .send_data (send_data),
        .ready     (ready),
        .tx_line   (tx_line),
        .rx_line   (rx_line),
        .rx_valid  (rx_valid),
        .rx_word   (rx_word)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                          // 20 ns period
    end

    always @(negedge clk) begin
        if (rx_valid) valid_seen++;                      // Stable half a cycle after edge
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic check(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("Mismatch at %0t: %s", $time, msg);
        end
    endtask

    task automatic report(input string name, input int chk0, input int err0);
        $display("Test %s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready) begin
            @(posedge clk);
            #2;
            n++;
            if (n == TIMEOUT) fail_run("Timed out waiting for ready to rise");
        end
    endtask

    task automatic send_nibble(input nibble_t d);
        wait_ready();
        send      = 1'b1;
        send_data = d;
        @(posedge clk);
        #2;
        send = 1'b0;                                     // Single-cycle strobe
    endtask

    // Mask bit 0 start, 1..8 code bits, 9 UART parity, 10 stop
    task automatic inject_errors(input logic [10:0] flips);
        int n;
        n = 0;
        while (tx_line) begin                            // Wait for start bit
            @(posedge clk);
            #2;
            n++;
            if (n == TIMEOUT) fail_run("Start bit never appeared on tx_line");
        end
        check(ready === 1'b0, "ready high during a frame");
        for (int k = 0; k < FRAME_BITS; k++) begin
            line_flip = flips[k];                        // One bit period each
            repeat (CLKS_PER_BIT) @(posedge clk);
            #2;
        end
        line_flip = 1'b0;
    endtask

    task automatic wait_rx(output rx_word_t got);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #2;
            n++;
            if (n == TIMEOUT) fail_run("Timed out waiting for rx_valid");
        end while (!rx_valid);
        got = rx_word;
    endtask

    task automatic poke_send(input nibble_t d);
        repeat (3 * CLKS_PER_BIT) @(posedge clk);        // Well inside the frame
        #2;
        check(ready === 1'b0, "ready high mid-frame");
        send      = 1'b1;                                // Must be ignored
        send_data = d;
        @(posedge clk);
        #2;
        send = 1'b0;
    endtask

    task automatic check_word(input nibble_t d, input logic [10:0] flips,
                              input rx_word_t got);
        code_t    sent;
        code_t    seen;
        int       nflip;
        rx_word_t exp;
        sent  = secded_encode(d);
        seen  = sent ^ flips[8:1];                       // Word as the receiver sees it
        nflip = $countones(flips[8:1]);
        exp.data          = (nflip == 2) ? {seen[7], seen[6], seen[5], seen[3]} : d;
        exp.corrected     = (nflip == 1);
        exp.uncorrectable = (nflip == 2);
        exp.parity_error  = ^flips[9:1];                 // Odd flips over byte and parity
        exp.framing_error = flips[10];
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t: nibble %h flips %b got %b expected %b",
                     $time, d, flips, got, exp);
        end
    endtask

    task automatic run_frame(input nibble_t d, input logic [10:0] flips, input bit poke);
        rx_word_t got;
        send_nibble(d);
        fork
            inject_errors(flips);
            wait_rx(got);
            if (poke) poke_send(~d);
        join
        check_word(d, flips, got);
    endtask

    initial begin
        int chk0;
        int err0;
        int i;
        int j;
        int n;
        bit idle_ok;
        void'($urandom(32'h3336_a313));
        rst_n      = 1'b0;
        send       = 1'b0;
        send_data  = '0;
        line_flip  = 1'b0;
        checks     = 0;
        errors     = 0;
        valid_seen = 0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;

        chk0 = checks;
        err0 = errors;
        check(ready === 1'b1, "ready low after reset");
        check(tx_line === 1'b1, "tx_line low after reset");
        check(rx_valid === 1'b0, "rx_valid high after reset");
        report("reset state", chk0, err0);

        chk0 = checks;
        err0 = errors;
        for (i = 0; i < 16; i++) run_frame(4'(i), '0, 1'b0);
        repeat (50) run_frame(4'($urandom), '0, 1'b0);
        report("clean loopback", chk0, err0);

        chk0 = checks;
        err0 = errors;
        for (i = 0; i < 8; i++) run_frame(4'($urandom), 11'(1) << (i + 1), 1'b0);
        report("single-bit error", chk0, err0);

        chk0 = checks;
        err0 = errors;
        repeat (20) begin
            i = $urandom % 8;
            j = (i + 1 + $urandom % 7) % 8;              // Always distinct from i
            run_frame(4'($urandom), (11'(1) << (i + 1)) | (11'(1) << (j + 1)), 1'b0);
        end
        report("double-bit error", chk0, err0);

        chk0 = checks;
        err0 = errors;
        repeat (4) run_frame(4'($urandom), 11'(1) << 9, 1'b0);    // UART parity bit
        repeat (4) run_frame(4'($urandom), 11'(1) << 10, 1'b0);   // Stop bit
        report("parity and stop hit", chk0, err0);

        chk0 = checks;
        err0 = errors;
        n = valid_seen;
        run_frame(4'($urandom), '0, 1'b1);
        wait_ready();
        idle_ok = 1'b1;
        repeat (2 * FRAME_BITS * CLKS_PER_BIT) begin     // Quiet line, no new frame
            @(posedge clk);
            #2;
            if (tx_line !== 1'b1) idle_ok = 1'b0;
        end
        check(idle_ok, "tx_line left idle without a send");
        check(valid_seen == n + 1, "ignored send produced an extra rx_valid");
        check(ready === 1'b1, "ready low while idle");
        report("ready and ignored send", chk0, err0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* source/link_pkg.sv */
package link_pkg;

    localparam int FRAME_BITS = 11;                      // Start, 8 data, parity, stop

    typedef logic [3:0] nibble_t;                        // Payload value
    typedef logic [7:0] code_t;                          // Bit 0 overall parity, 1..7 Hamming

    typedef struct packed {
        nibble_t data;                                   // Decoded payload
        logic    corrected;                              // Single error fixed
        logic    uncorrectable;                          // Double error seen
        logic    parity_error;                           // UART parity mismatch
        logic    framing_error;                          // Stop bit was low
    } rx_word_t;

    typedef struct packed {
        code_t code;                                     // Raw received byte
        logic  parity_error;
        logic  framing_error;
    } uart_word_t;

    // Hamming (7,4) with check bits at 1, 2, 4 and overall parity in bit 0
    function automatic code_t secded_encode(input nibble_t d);
        code_t c;
        c      = '0;
        c[3]   = d[0];                                   // Data positions
        c[5]   = d[1];
        c[6]   = d[2];
        c[7]   = d[3];
        c[1]   = c[3] ^ c[5] ^ c[7];                     // Covers odd positions
        c[2]   = c[3] ^ c[6] ^ c[7];
        c[4]   = c[5] ^ c[6] ^ c[7];
        c[0]   = ^c[7:1];                                // Even over all 8 bits
        return c;
    endfunction

    function automatic logic [2:0] secded_syndrome(input code_t c);
        logic [2:0] s;
        s[0] = c[1] ^ c[3] ^ c[5] ^ c[7];
        s[1] = c[2] ^ c[3] ^ c[6] ^ c[7];
        s[2] = c[4] ^ c[5] ^ c[6] ^ c[7];
        return s;                                        // Position of a single flip
    endfunction

endpackage

/* source/link_rx.sv */
`timescale 1ns/1ps

module link_rx import link_pkg::*; #(
    parameter int CLK_FREQ   = 50_000_000,
    parameter int BAUD_RATE  = 5_000_000,
    parameter bit ODD_PARITY = 1'b0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     rx_line,
    output logic     rx_valid,                           // 1-cycle, with rx_word
    output rx_word_t rx_word
);

    logic       u_done;
    uart_word_t u_word;
    logic [2:0] syn;
    logic       odd_all;                                 // Overall parity fails
    rx_word_t   dec;

    assign syn     = secded_syndrome(u_word.code);
    assign odd_all = ^u_word.code;

    // SECDED decode of the raw byte
    always_comb begin
        code_t fixed;
        fixed             = u_word.code;
        dec.corrected     = 1'b0;
        dec.uncorrectable = 1'b0;
        if (syn != 3'd0 && odd_all) begin
            fixed[syn]    = ~fixed[syn];                 // Single error at syndrome position
            dec.corrected = 1'b1;
        end else if (syn == 3'd0 && odd_all) begin
            dec.corrected = 1'b1;                        // Only the overall bit was hit
        end else if (syn != 3'd0) begin
            dec.uncorrectable = 1'b1;                    // Even parity, nonzero syndrome
        end
        dec.data          = {fixed[7], fixed[6], fixed[5], fixed[3]};
        dec.parity_error  = u_word.parity_error;         // Passed through as is
        dec.framing_error = u_word.framing_error;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= u_done;
        end
    end

    always_ff @(posedge clk) begin
        if (u_done) rx_word <= dec;
    end

    uart_rx #(
        .CLK_FREQ   (CLK_FREQ),
        .BAUD_RATE  (BAUD_RATE),
        .ODD_PARITY (ODD_PARITY)
    ) uart_rx_i (
        .clk   (clk),
        .rst_n (rst_n),
        .line  (rx_line),
        .done  (u_done),
        .word  (u_word)
    );

endmodule

/* source/link_top.sv */
`timescale 1ns/1ps

module link_top import link_pkg::*; #(
    parameter int CLK_FREQ   = 50_000_000,
    parameter int BAUD_RATE  = 5_000_000,
    parameter bit ODD_PARITY = 1'b0                      // 0 even, 1 odd
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     send,
    input  nibble_t  send_data,
    output logic     ready,
    output logic     tx_line,                            // Serial out
    input  logic     rx_line,                            // Serial in
    output logic     rx_valid,
    output rx_word_t rx_word
);

    link_tx #(
        .CLK_FREQ   (CLK_FREQ),
        .BAUD_RATE  (BAUD_RATE),
        .ODD_PARITY (ODD_PARITY)
    ) link_tx_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .send      (send),
        .send_data (send_data),
        .ready     (ready),
        .tx_line   (tx_line)
    );

    link_rx #(
        .CLK_FREQ   (CLK_FREQ),
        .BAUD_RATE  (BAUD_RATE),
        .ODD_PARITY (ODD_PARITY)
    ) link_rx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_line  (rx_line),
        .rx_valid (rx_valid),
        .rx_word  (rx_word)
    );

endmodule

/* source/link_tx.sv */
`timescale 1ns/1ps

module link_tx import link_pkg::*; #(
    parameter int CLK_FREQ   = 50_000_000,
    parameter int BAUD_RATE  = 5_000_000,
    parameter bit ODD_PARITY = 1'b0
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    send,                                // 1-cycle request
    input  nibble_t send_data,
    output logic    ready,                               // High when a send is taken
    output logic    tx_line
);

    logic  accept;
    logic  start_q;                                      // Launch strobe to serializer
    logic  busy;
    code_t code_q;                                       // Held for the whole frame

    assign accept = send && ready;                       // Sends while busy are dropped

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready   <= 1'b1;
            start_q <= 1'b0;
        end else begin
            start_q <= accept;
            if (accept) begin
                ready <= 1'b0;
            end else if (!ready && !start_q && !busy) begin
                ready <= 1'b1;                           // Serializer back to idle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) code_q <= secded_encode(send_data);
    end

    uart_tx #(
        .CLK_FREQ   (CLK_FREQ),
        .BAUD_RATE  (BAUD_RATE),
        .ODD_PARITY (ODD_PARITY)
    ) uart_tx_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start_q),
        .code  (code_q),
        .busy  (busy),
        .line  (tx_line)
    );

endmodule

/* source/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx import link_pkg::*; #(
    parameter int CLK_FREQ   = 50_000_000,
    parameter int BAUD_RATE  = 5_000_000,
    parameter bit ODD_PARITY = 1'b0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       line,                             // Asynchronous serial input
    output logic       done,                             // 1-cycle, word valid with it
    output uart_word_t word
);

    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_t;

    rx_state_t        state;
    logic [1:0]       sync;                              // Two-flop synchronizer
    logic             line_s;
    logic             line_d;                            // For falling edge detect
    logic [CNT_W-1:0] cnt;
    logic [2:0]       idx;
    code_t            shreg;                             // LSB arrives first
    logic             par_q;                             // Sampled parity bit
    logic             bit_mid;
    logic             half_mid;
    logic             stop_hit;

    assign line_s   = sync[1];
    assign bit_mid  = (cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign half_mid = (cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));
    assign stop_hit = (state == RX_STOP) && bit_mid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync   <= 2'b11;                             // Line idles high
            line_d <= 1'b1;
            state  <= RX_IDLE;
            cnt    <= '0;
            idx    <= '0;
            done   <= 1'b0;
        end else begin
            sync   <= {sync[0], line};
            line_d <= line_s;
            done   <= stop_hit;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (line_d && !line_s) state <= RX_START;   // Falling edge
                end
                RX_START: begin
                    if (half_mid) begin
                        cnt   <= '0;
                        idx   <= '0;
                        state <= line_s ? RX_IDLE : RX_DATA;    // Reject glitch
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_mid) begin
                        cnt <= '0;
                        idx <= idx + 1'b1;
                        if (idx == 3'd7) state <= RX_PARITY;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_PARITY: begin
                    if (bit_mid) begin
                        cnt   <= '0;
                        state <= RX_STOP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin                           // Stop bit
                    if (bit_mid) state <= RX_IDLE;       // Back to idle at stop centre
                    else cnt <= cnt + 1'b1;
                end
            endcase
        end
    end

    // Payload capture at the bit centres
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_mid) shreg <= {line_s, shreg[7:1]};
        if (state == RX_PARITY && bit_mid) par_q <= line_s;
        if (stop_hit) begin
            word.code          <= shreg;
            word.parity_error  <= ODD_PARITY ? ~(^{shreg, par_q}) : ^{shreg, par_q};
            word.framing_error <= ~line_s;               // Stop must be high
        end
    end

endmodule

/* source/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx import link_pkg::*; #(
    parameter int CLK_FREQ   = 50_000_000,
    parameter int BAUD_RATE  = 5_000_000,
    parameter bit ODD_PARITY = 1'b0
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,                                 // 1-cycle launch strobe
    input  code_t code,                                  // Held stable by caller while busy
    output logic  busy,
    output logic  line
);

    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_t;

    tx_state_t  state;
    logic [CNT_W-1:0] cnt;                               // Cycles within a bit period
    logic [2:0] idx;                                     // Data bit being sent
    logic       par;
    logic       bit_end;

    assign par     = ODD_PARITY ? ~(^code) : ^code;      // Makes total ones even or odd
    assign bit_end = (cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign busy    = (state != TX_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= TX_IDLE;
            cnt   <= '0;
            idx   <= '0;
            line  <= 1'b1;                               // Idle high
        end else if (state == TX_IDLE) begin
            line <= 1'b1;
            cnt  <= '0;
            if (start) begin
                state <= TX_START;
                line  <= 1'b0;                           // Start bit from next cycle
            end
        end else if (!bit_end) begin
            cnt <= cnt + 1'b1;
        end else begin
            cnt <= '0;
            case (state)
                TX_START: begin
                    state <= TX_DATA;
                    idx   <= '0;
                    line  <= code[0];                    // LSB first
                end
                TX_DATA: begin
                    if (idx == 3'd7) begin
                        state <= TX_PARITY;
                        line  <= par;
                    end else begin
                        idx  <= idx + 1'b1;
                        line <= code[idx + 3'd1];
                    end
                end
                TX_PARITY: begin
                    state <= TX_STOP;
                    line  <= 1'b1;
                end
                default: begin                           // End of stop bit
                    state <= TX_IDLE;
                    line  <= 1'b1;
                end
            endcase
        end
    end

endmodule
